/* source/fetch_pkg.sv */
// Fixed to a 64-bit AXI-lite read bus that carries two 32-bit instructions per word
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////
	// Bus and instruction geometry
	//////////////////////////////////////////////////

	// Byte address width
	localparam int ADDR_WIDTH = 32;
	// AXI read data width
	localparam int BUS_WIDTH = 64;
	localparam int INSN_WIDTH = 32;
	localparam int INSNS_PER_WORD = BUS_WIDTH / INSN_WIDTH;
	// Byte offset bits within one bus word
	localparam int WORD_LSB = 3;

	// Most words requested and not yet consumed
	localparam int FETCH_LIMIT = 8;
	localparam int LGFIFO = 3;
	// Outstanding counter is far wider than the limit needs
	localparam int LGDEPTH = LGFIFO + 4;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [BUS_WIDTH-1:0] bus_word_t;
	typedef logic [INSN_WIDTH-1:0] insn_t;
	// Outstanding and flush counts
	typedef logic [LGDEPTH:0] depth_t;
	// Request fill count
	typedef logic [LGDEPTH-1:0] fill_t;

	// AXI response codes, upper bit set means a bus error
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

endpackage

`default_nettype wire

/* source/flush_tracker.sv */
// Assumes every R beat answers an earlier AR handshake and RREADY is always high
`default_nettype none

module flush_tracker (
	input  logic S_AXI_ACLK,
	input  logic fifo_reset,
	input  logic i_new_pc,
	input  logic i_arvalid,
	input  logic i_arready,
	input  logic i_rvalid,
	output logic o_full_bus,
	output logic o_flush_request,
	output logic o_keep_beat
);

	fetch_pkg::depth_t outstanding;
	fetch_pkg::depth_t next_outstanding;
	fetch_pkg::depth_t new_flushcount;
	fetch_pkg::depth_t flushcount;
	logic flushing;

	// Reads in flight after this cycle
	always_comb
	begin
		next_outstanding = outstanding;
		case ({ i_arvalid && i_arready, i_rvalid })
		2'b10: next_outstanding = outstanding + 1'b1;
		2'b01: next_outstanding = outstanding - 1'b1;
		default: next_outstanding = outstanding;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			outstanding <= '0;
			o_full_bus <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			// Stop one short of wrapping the counter
			o_full_bus <= (next_outstanding
				>= fetch_pkg::depth_t'((1 << fetch_pkg::LGDEPTH) - 1));
		end
	end

	//////////////////////////////////////////////////
	// Redirect flush
	//////////////////////////////////////////////////

	// In flight plus the one being presented, less a beat landing now
	assign new_flushcount = outstanding + fetch_pkg::depth_t'(i_arvalid)
		- fetch_pkg::depth_t'(i_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			flushcount <= '0;
			flushing <= 1'b0;
			o_flush_request <= 1'b0;
		end
		else if (i_new_pc)
		begin
			flushcount <= new_flushcount;
			flushing <= (new_flushcount != 0);
			// Stalled request goes out later but is already stale
			o_flush_request <= i_arvalid && !i_arready;
		end
		else
		begin
			if (i_rvalid && flushcount != 0)
			begin
				flushcount <= flushcount - 1'b1;
				flushing <= (flushcount > 1);
			end
			if (i_arready)
				o_flush_request <= 1'b0;
		end
	end

	// Beats that survive go on to the FIFO
	assign o_keep_beat = i_rvalid && !flushing;

	a_flushing_matches: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		flushing == (flushcount != 0));

	// A beat needs an earlier handshake to answer
	a_no_underflow: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		i_rvalid |-> (outstanding != 0));

endmodule

`default_nettype wire

/* source/axil_request.sv */
// No requests go out until the first redirect after reset supplies a program counter
`default_nettype none

module axil_request (
	input  logic S_AXI_ACLK,
	input  logic fifo_reset,
	input  logic i_new_pc,
	input  fetch_pkg::addr_t i_pc,
	input  logic i_arready,
	input  logic i_full_bus,
	input  logic i_flush_request,
	input  logic i_word_taken,
	input  logic i_out_busy,
	output logic o_arvalid,
	output fetch_pkg::addr_t o_araddr
);

	fetch_pkg::fill_t fill;
	fetch_pkg::depth_t demand;
	fetch_pkg::addr_t pending_pc;
	logic pending_new_pc;
	logic running;
	logic issue;

	// Free to load the next request
	assign issue = !o_arvalid || i_arready;

	// Words requested and not yet read out of the FIFO
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_new_pc)
			fill <= '0;
		else
		begin
			case ({ o_arvalid && i_arready && !i_flush_request, i_word_taken })
			2'b10: fill <= fill + 1'b1;
			2'b01: fill <= fill - 1'b1;
			default: fill <= fill;
			endcase
		end
	end

	// Fill plus the request on the bus plus a busy output stage
	assign demand = fetch_pkg::depth_t'(fill) + fetch_pkg::depth_t'(o_arvalid)
		+ fetch_pkg::depth_t'(i_out_busy);

	// Set once a program counter is known
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			running <= 1'b0;
		else if (i_new_pc)
			running <= 1'b1;
	end

	//////////////////////////////////////////////////
	// AR channel
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_arvalid <= 1'b0;
		else if (issue)
		begin
			o_arvalid <= running || i_new_pc;
			// Throttle, fill is stale on a redirect
			if (!i_new_pc && demand >= fetch_pkg::depth_t'(fetch_pkg::FETCH_LIMIT))
				o_arvalid <= 1'b0;
			if (i_full_bus)
				o_arvalid <= 1'b0;
		end
	end

	// Redirect that landed on a stalled request
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || issue)
			pending_new_pc <= 1'b0;
		else if (i_new_pc)
			pending_new_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_pc <= i_pc;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (issue)
		begin
			if (i_new_pc)
				o_araddr <= i_pc;
			else if (pending_new_pc)
				o_araddr <= pending_pc;
			else if (o_arvalid)
			begin
				// Next bus word, byte offset cleared
				o_araddr[fetch_pkg::ADDR_WIDTH-1:fetch_pkg::WORD_LSB]
					<= o_araddr[fetch_pkg::ADDR_WIDTH-1:fetch_pkg::WORD_LSB] + 1'b1;
				o_araddr[fetch_pkg::WORD_LSB-1:0] <= '0;
			end
		end
	end

	a_araddr_stable: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

endmodule

`default_nettype wire

/* source/sync_fifo.sv */
// First word falls through combinationally, the caller must never write when full
`default_nettype none

module sync_fifo (
	input  logic S_AXI_ACLK,
	input  logic fifo_reset,
	input  logic i_flush,
	input  logic i_wr,
	input  fetch_pkg::bus_word_t i_data,
	input  logic i_err,
	input  logic i_rd,
	output fetch_pkg::bus_word_t o_data,
	output logic o_err,
	output logic o_empty
);

	localparam int DEPTH = 1 << fetch_pkg::LGFIFO;

	fetch_pkg::bus_word_t mem [DEPTH];
	logic err_mem [DEPTH];
	// Extra top bit tells full from empty
	logic [fetch_pkg::LGFIFO:0] wr_ptr;
	logic [fetch_pkg::LGFIFO:0] rd_ptr;
	logic full;
	logic rd_en;

	assign o_empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[fetch_pkg::LGFIFO] != rd_ptr[fetch_pkg::LGFIFO])
		&& (wr_ptr[fetch_pkg::LGFIFO-1:0] == rd_ptr[fetch_pkg::LGFIFO-1:0]);
	assign rd_en = i_rd && !o_empty;

	// Storage
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
		begin
			mem[wr_ptr[fetch_pkg::LGFIFO-1:0]] <= i_data;
			err_mem[wr_ptr[fetch_pkg::LGFIFO-1:0]] <= i_err;
		end
	end

	// Pointers, a redirect empties like reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign o_data = mem[rd_ptr[fetch_pkg::LGFIFO-1:0]];
	assign o_err = err_mem[rd_ptr[fetch_pkg::LGFIFO-1:0]];

	// Request throttle upstream keeps room for every kept beat
	a_no_overflow: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		i_wr && !i_flush |-> !full);

endmodule

`default_nettype wire

/* source/insn_unpack.sv */
// Bytes are always swapped per 32-bit lane, o_pc freezes once an error word is seen
`default_nettype none

module insn_unpack (
	input  logic S_AXI_ACLK,
	input  logic fifo_reset,
	input  logic i_new_pc,
	input  fetch_pkg::addr_t i_pc,
	input  logic i_ready,
	input  fetch_pkg::bus_word_t i_data,
	input  logic i_err,
	input  logic i_empty,
	output logic o_fifo_rd,
	output logic o_word_taken,
	output logic o_out_busy,
	output logic o_valid,
	output fetch_pkg::insn_t o_insn,
	output fetch_pkg::addr_t o_pc,
	output logic o_illegal
);

	localparam int FILLBITS = $clog2(fetch_pkg::INSNS_PER_WORD);

	fetch_pkg::bus_word_t swapped;
	fetch_pkg::bus_word_t out_data;
	logic [FILLBITS:0] out_fill;
	logic shift;

	// Byte reverse within each lane
	always_comb
	begin
		for (int lane = 0; lane < fetch_pkg::INSNS_PER_WORD; lane++)
		begin
			for (int b = 0; b < 4; b++)
			begin
				swapped[lane*fetch_pkg::INSN_WIDTH + (3-b)*8 +: 8]
					= i_data[lane*fetch_pkg::INSN_WIDTH + b*8 +: 8];
			end
		end
	end

	// Skip the lower insn only when entering at an odd address
	assign shift = o_valid ? 1'b0 : o_pc[fetch_pkg::WORD_LSB-1];

	// Refill once the last insn of the word goes
	assign o_fifo_rd = !o_valid || (i_ready && out_fill <= 1);
	assign o_word_taken = o_fifo_rd && !i_empty;
	// Still holding something next cycle
	assign o_out_busy = o_valid && (!i_ready || out_fill > 1);

	//////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_new_pc)
			out_fill <= '0;
		else if (o_fifo_rd)
			out_fill <= i_empty ? '0
				: (FILLBITS+1)'(fetch_pkg::INSNS_PER_WORD) - {1'b0, shift};
		else if (i_ready && out_fill != 0)
			out_fill <= out_fill - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_new_pc)
			o_valid <= 1'b0;
		else if (!o_valid || i_ready)
			o_valid <= (o_fifo_rd && !i_empty) || (out_fill > (o_valid ? 1 : 0));
	end

	// Shift register of pending insns
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_fifo_rd)
			out_data <= shift ? (swapped >> fetch_pkg::INSN_WIDTH) : swapped;
		else if (i_ready)
			out_data <= out_data >> fetch_pkg::INSN_WIDTH;
	end

	assign o_insn = out_data[fetch_pkg::INSN_WIDTH-1:0];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_pc <= '0;
		else if (i_new_pc)
			o_pc <= i_pc;
		else if (o_valid && i_ready && !o_illegal)
		begin
			o_pc[fetch_pkg::ADDR_WIDTH-1:2] <= o_pc[fetch_pkg::ADDR_WIDTH-1:2] + 1'b1;
			o_pc[1:0] <= 2'b00;
		end
	end

	// Sticky until the next redirect
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_new_pc)
			o_illegal <= 1'b0;
		else if (!o_illegal && o_word_taken)
			o_illegal <= i_err;
	end

	a_valid_fill: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		o_valid == (out_fill != 0));

endmodule

`default_nettype wire

/* source/axil_fetch.sv */
// Read-only AXI-lite master, ARPROT is tied by the fabric and RREADY is always high
`default_nettype none

module axil_fetch (
	input  logic S_AXI_ACLK,
	input  logic fifo_reset,
	// CPU side
	input  logic i_new_pc,
	input  fetch_pkg::addr_t i_pc,
	input  logic i_ready,
	output fetch_pkg::insn_t o_insn,
	output fetch_pkg::addr_t o_pc,
	output logic o_valid,
	output logic o_illegal,
	// AXI-lite read channels
	output logic M_AXI_ARVALID,
	input  logic M_AXI_ARREADY,
	output fetch_pkg::addr_t M_AXI_ARADDR,
	input  logic M_AXI_RVALID,
	output logic M_AXI_RREADY,
	input  fetch_pkg::bus_word_t M_AXI_RDATA,
	input  logic [1:0] M_AXI_RRESP
);

	fetch_pkg::axi_resp_e rresp;
	fetch_pkg::bus_word_t fifo_data;
	logic rd_err;
	logic full_bus;
	logic flush_request;
	logic keep_beat;
	logic fifo_err;
	logic fifo_empty;
	logic fifo_rd;
	logic word_taken;
	logic out_busy;

	assign M_AXI_RREADY = 1'b1;

	// Slave or decode error
	assign rresp = fetch_pkg::axi_resp_e'(M_AXI_RRESP);
	assign rd_err = (rresp == fetch_pkg::RESP_SLVERR) || (rresp == fetch_pkg::RESP_DECERR);

	flush_tracker u_flush (
		.S_AXI_ACLK(S_AXI_ACLK), .fifo_reset(fifo_reset), .i_new_pc(i_new_pc),
		.i_arvalid(M_AXI_ARVALID), .i_arready(M_AXI_ARREADY),
		.i_rvalid(M_AXI_RVALID), .o_full_bus(full_bus),
		.o_flush_request(flush_request), .o_keep_beat(keep_beat));

	axil_request u_request (
		.S_AXI_ACLK(S_AXI_ACLK), .fifo_reset(fifo_reset), .i_new_pc(i_new_pc),
		.i_pc(i_pc), .i_arready(M_AXI_ARREADY), .i_full_bus(full_bus),
		.i_flush_request(flush_request), .i_word_taken(word_taken),
		.i_out_busy(out_busy), .o_arvalid(M_AXI_ARVALID), .o_araddr(M_AXI_ARADDR));

	// Raw beats are stored, swapping happens on the way out
	sync_fifo u_fifo (
		.S_AXI_ACLK(S_AXI_ACLK), .fifo_reset(fifo_reset), .i_flush(i_new_pc),
		.i_wr(keep_beat), .i_data(M_AXI_RDATA), .i_err(rd_err), .i_rd(fifo_rd),
		.o_data(fifo_data), .o_err(fifo_err), .o_empty(fifo_empty));

	insn_unpack u_unpack (
		.S_AXI_ACLK(S_AXI_ACLK), .fifo_reset(fifo_reset), .i_new_pc(i_new_pc),
		.i_pc(i_pc), .i_ready(i_ready), .i_data(fifo_data), .i_err(fifo_err),
		.i_empty(fifo_empty), .o_fifo_rd(fifo_rd), .o_word_taken(word_taken),
		.o_out_busy(out_busy), .o_valid(o_valid), .o_insn(o_insn), .o_pc(o_pc),
		.o_illegal(o_illegal));

endmodule

`default_nettype wire

/* testbench/axil_mem_model.sv */
// Answers reads in order, one beat per request, and assumes RREADY is held high
`default_nettype none

module axil_mem_model #(
	parameter int SEED = 32'h4fd0,
	parameter fetch_pkg::addr_t ERR_BASE = 32'h0000_2000
) (
	input  logic S_AXI_ACLK,
	input  logic fifo_reset,
	input  logic i_arvalid,
	input  fetch_pkg::addr_t i_araddr,
	output logic o_arready,
	output logic o_rvalid,
	output fetch_pkg::bus_word_t o_rdata,
	output logic [1:0] o_rresp
);
	timeunit 1ns;
	timeprecision 100ps;

	int seed = SEED;
	// Accepted addresses waiting for their beat
	fetch_pkg::addr_t pending [$];
	fetch_pkg::addr_t beat_addr;

	function automatic fetch_pkg::insn_t swap_bytes(input fetch_pkg::insn_t v);
		swap_bytes = {v[7:0], v[15:8], v[23:16], v[31:24]};
	endfunction

	// Lower lane holds the lower address
	function automatic fetch_pkg::bus_word_t word_at(input fetch_pkg::addr_t a);
		fetch_pkg::addr_t base;
		base = a & ~fetch_pkg::addr_t'((1 << fetch_pkg::WORD_LSB) - 1);
		word_at = {swap_bytes((base + 4) ^ 32'h5A5A0000), swap_bytes(base ^ 32'h5A5A0000)};
	endfunction

	// Idle bus until the first clock edge
	initial
	begin
		o_arready = 1'b0;
		o_rvalid = 1'b0;
		o_rdata = '0;
		o_rresp = fetch_pkg::RESP_OKAY;
	end

	always @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			pending.delete();
			o_arready <= 1'b0;
			o_rvalid <= 1'b0;
			o_rdata <= '0;
			o_rresp <= fetch_pkg::RESP_OKAY;
		end
		else
		begin
			if (i_arvalid && o_arready)
				pending.push_back(i_araddr);
			// Address stalls about a quarter of the time
			o_arready <= ($random(seed) & 3) != 0;
			o_rvalid <= 1'b0;
			// Beat delayed at random
			if (pending.size() != 0 && ($random(seed) & 1) != 0)
			begin
				beat_addr = pending.pop_front();
				o_rvalid <= 1'b1;
				if (beat_addr >= ERR_BASE)
				begin
					o_rdata <= '0;
					o_rresp <= fetch_pkg::RESP_SLVERR;
				end
				else
				begin
					o_rdata <= word_at(beat_addr);
					o_rresp <= fetch_pkg::RESP_OKAY;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_axil_fetch.sv */
// Directed fetch tests against a randomly stalling memory model that end at the first mismatch
`default_nettype none

module tb_axil_fetch;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SEED = 32'h4fd0;
	localparam fetch_pkg::addr_t ERR_BASE = 32'h0000_2000;
	localparam fetch_pkg::insn_t INSN_XOR = 32'h5A5A0000;
	// Instruction counts per test
	localparam int N_ALIGNED = 40;
	localparam int N_ODD = 20;
	localparam int N_STALL = 30;
	localparam int N_BACKPRESS = 24;
	localparam int N_FIRST = 6;
	localparam int N_REDIRECT = 12;
	localparam int N_ERR_GOOD = 4;
	localparam int N_ERR_HELD = 3;
	localparam int N_RESUME = 8;
	localparam int TOTAL_INSNS = N_ALIGNED + N_ODD + N_STALL + N_BACKPRESS + N_FIRST
		+ N_REDIRECT + N_ERR_GOOD + N_ERR_HELD + N_RESUME;
	localparam int WATCHDOG_CYCLES = TOTAL_INSNS * 64;
	// Cycles to let the FIFO fill with the CPU stalled
	localparam int BP_WAIT = 150;

	logic S_AXI_ACLK;
	logic fifo_reset;
	logic i_new_pc;
	fetch_pkg::addr_t i_pc;
	logic i_ready;
	fetch_pkg::insn_t o_insn;
	fetch_pkg::addr_t o_pc;
	logic o_valid;
	logic o_illegal;
	logic M_AXI_ARVALID;
	logic M_AXI_ARREADY;
	fetch_pkg::addr_t M_AXI_ARADDR;
	logic M_AXI_RVALID;
	logic M_AXI_RREADY;
	fetch_pkg::bus_word_t M_AXI_RDATA;
	logic [1:0] M_AXI_RRESP;

	int seed = SEED;
	int ar_count;
	logic ar_stalled;
	fetch_pkg::addr_t ar_held_addr;

	axil_fetch UUT (
		.S_AXI_ACLK(S_AXI_ACLK), .fifo_reset(fifo_reset), .i_new_pc(i_new_pc),
		.i_pc(i_pc), .i_ready(i_ready), .o_insn(o_insn), .o_pc(o_pc),
		.o_valid(o_valid), .o_illegal(o_illegal), .M_AXI_ARVALID(M_AXI_ARVALID),
		.M_AXI_ARREADY(M_AXI_ARREADY), .M_AXI_ARADDR(M_AXI_ARADDR),
		.M_AXI_RVALID(M_AXI_RVALID), .M_AXI_RREADY(M_AXI_RREADY),
		.M_AXI_RDATA(M_AXI_RDATA), .M_AXI_RRESP(M_AXI_RRESP));

	axil_mem_model #(.SEED(SEED), .ERR_BASE(ERR_BASE)) u_mem (
		.S_AXI_ACLK(S_AXI_ACLK), .fifo_reset(fifo_reset), .i_arvalid(M_AXI_ARVALID),
		.i_araddr(M_AXI_ARADDR), .o_arready(M_AXI_ARREADY), .o_rvalid(M_AXI_RVALID),
		.o_rdata(M_AXI_RDATA), .o_rresp(M_AXI_RRESP));

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	//////////////////////////////////////////////////
	// Compare helpers
	//////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_insn(input string name, input fetch_pkg::insn_t exp,
		input fetch_pkg::insn_t act);
		if (exp !== act)
			abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_pc(input string name, input fetch_pkg::addr_t exp,
		input fetch_pkg::addr_t act);
		if (exp !== act)
			abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
			abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	// AR handshakes seen on the bus, and a stalled request keeps its address
	always @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			ar_stalled = 1'b0;
		else
		begin
			if (ar_stalled)
			begin
				check_flag("M_AXI_ARVALID", 1'b1, M_AXI_ARVALID);
				check_pc("M_AXI_ARADDR", ar_held_addr, M_AXI_ARADDR);
			end
			if (M_AXI_ARVALID && M_AXI_ARREADY)
				ar_count = ar_count + 1;
			ar_stalled = M_AXI_ARVALID && !M_AXI_ARREADY;
			ar_held_addr = M_AXI_ARADDR;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic do_reset();
		@(posedge S_AXI_ACLK);
		fifo_reset <= 1'b1;
		i_new_pc <= 1'b0;
		repeat (2) @(posedge S_AXI_ACLK);
		fifo_reset <= 1'b0;
	endtask

	// One-cycle redirect pulse and an empty output the cycle after
	task automatic redirect(input fetch_pkg::addr_t pc);
		@(posedge S_AXI_ACLK);
		i_new_pc <= 1'b1;
		i_pc <= pc;
		@(posedge S_AXI_ACLK);
		i_new_pc <= 1'b0;
		@(posedge S_AXI_ACLK);
		check_flag("o_valid", 1'b0, o_valid);
		check_flag("o_illegal", 1'b0, o_illegal);
	endtask

	// Expected values only advance on a consumed instruction
	task automatic expect_stream(input fetch_pkg::addr_t start, input int count,
		input bit random_ready);
		fetch_pkg::addr_t exp_pc;
		int taken;
		logic held;
		exp_pc = start;
		taken = 0;
		held = 1'b0;
		while (taken < count)
		begin
			@(posedge S_AXI_ACLK);
			if (held)
				check_flag("o_valid", 1'b1, o_valid);
			if (o_valid)
			begin
				check_pc("o_pc", exp_pc, o_pc);
				check_insn("o_insn", exp_pc ^ INSN_XOR, o_insn);
				check_flag("o_illegal", 1'b0, o_illegal);
				if (i_ready)
				begin
					exp_pc = exp_pc + 4;
					taken++;
				end
			end
			held = o_valid && !i_ready;
			if (random_ready)
				i_ready <= ($random(seed) & 3) != 0;
			else
				i_ready <= 1'b1;
		end
	endtask

	// Frozen pc and sticky flag after a bus error
	task automatic watch_illegal(input fetch_pkg::addr_t pc, input int count);
		int taken;
		taken = 0;
		while (taken < count)
		begin
			@(posedge S_AXI_ACLK);
			if (o_valid)
			begin
				check_flag("o_illegal", 1'b1, o_illegal);
				check_pc("o_pc", pc, o_pc);
				if (i_ready)
					taken++;
			end
			i_ready <= 1'b1;
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic aligned_fetch();
		@(posedge S_AXI_ACLK);
		check_flag("M_AXI_ARVALID", 1'b0, M_AXI_ARVALID);
		check_flag("M_AXI_RREADY", 1'b1, M_AXI_RREADY);
		check_flag("o_valid", 1'b0, o_valid);
		check_flag("o_illegal", 1'b0, o_illegal);
		i_ready <= 1'b1;
		redirect(32'h0000_1000);
		expect_stream(32'h0000_1000, N_ALIGNED, 1'b0);
	endtask

	task automatic odd_entry();
		redirect(32'h0000_0104);
		expect_stream(32'h0000_0104, N_ODD, 1'b0);
	endtask

	task automatic ready_stalls();
		redirect(32'h0000_0400);
		expect_stream(32'h0000_0400, N_STALL, 1'b1);
	endtask

	task automatic backpressure();
		do_reset();
		i_ready <= 1'b0;
		ar_count = 0;
		redirect(32'h0000_0800);
		repeat (BP_WAIT) @(posedge S_AXI_ACLK);
		if (ar_count > fetch_pkg::FETCH_LIMIT)
			abort_run($sformatf("Fetch issued %0d reads with the CPU stalled", ar_count));
		expect_stream(32'h0000_0800, N_BACKPRESS, 1'b0);
	endtask

	// Second and third redirects land with reads still in flight
	task automatic redirect_in_flight();
		redirect(32'h0000_0C00);
		expect_stream(32'h0000_0C00, N_FIRST, 1'b1);
		redirect(32'h0000_1400);
		redirect(32'h0000_1804);
		expect_stream(32'h0000_1804, N_REDIRECT, 1'b1);
	endtask

	task automatic bus_error();
		redirect(ERR_BASE - 4 * N_ERR_GOOD);
		expect_stream(ERR_BASE - 4 * N_ERR_GOOD, N_ERR_GOOD, 1'b0);
		watch_illegal(ERR_BASE, N_ERR_HELD);
		redirect(32'h0000_0200);
		expect_stream(32'h0000_0200, N_RESUME, 1'b0);
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge S_AXI_ACLK);
		abort_run("Run timed out before all tests finished");
	end

	initial
	begin
		fifo_reset = 1'b1;
		i_new_pc = 1'b0;
		i_pc = '0;
		i_ready = 1'b0;
		ar_count = 0;
		do_reset();
		aligned_fetch();
		odd_entry();
		ready_stalls();
		backpressure();
		redirect_in_flight();
		bus_error();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
source/fetch_pkg.sv
source/flush_tracker.sv
source/axil_request.sv
source/sync_fifo.sv
source/insn_unpack.sv
source/axil_fetch.sv
testbench/axil_mem_model.sv
testbench/tb_axil_fetch.sv
